// ==== source/cpu_pipe_settings.svh ====
`ifndef CPU_PIPE_SETTINGS_SVH
`define CPU_PIPE_SETTINGS_SVH

// pipeline depth, one control bit per stage
// bit 0 is the pc, bit 5 is mem/wb
`define CPU_PIPE_STAGES 6

// data path width for pc and instruction word
`define CPU_PIPE_XLEN 32

// cycles a mul/div op keeps id/ex busy before it may advance
`define CPU_PIPE_MULDIV_CYCLES 4

// pc loaded while rst is high
`define CPU_PIPE_RESET_PC 32'h8000_0000

// redirect target when a trap flush wins
`define CPU_PIPE_TRAP_VECTOR 32'h8000_0100

`endif

// ==== source/cpu_pipe_pkg.sv ====
`include "cpu_pipe_settings.svh"

package cpu_pipe_pkg;

  // bit positions inside the stall and flush vectors
  typedef enum logic [2:0] {
    PC     = 3'd0,
    PRE_IF = 3'd1,
    IF_ID  = 3'd2,
    ID_EX  = 3'd3,
    EX_MEM = 3'd4,
    MEM_WB = 3'd5
  } stage_e;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate layout, shares rs1/rd/opcode positions with r_fmt_t
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // one instruction word, read through either view
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } rv_instr_u;

  // contents of one stage register
  typedef struct packed {
    logic                      valid;
    logic [`CPU_PIPE_XLEN-1:0] pc;
    rv_instr_u                 instr;
  } stage_rec_t;

  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_OP   = 7'b0110011;

  typedef logic [`CPU_PIPE_STAGES-1:0] ctl_vec_t;

  // stall/flush pairs per request
  // a stalled stage holds, so no bit is both stalled and flushed
  localparam ctl_vec_t RAM_MEM_STALL    = 6'b011111;
  localparam ctl_vec_t RAM_MEM_FLUSH    = 6'b100000;
  localparam ctl_vec_t RAM_IF_STALL     = 6'b000011;
  localparam ctl_vec_t RAM_IF_FLUSH     = 6'b000100;
  localparam ctl_vec_t NEXT_PREIF_STALL = 6'b000010;
  localparam ctl_vec_t NEXT_PREIF_FLUSH = 6'b000100;
  localparam ctl_vec_t TRAP_FLUSH_STALL = 6'b000000;
  localparam ctl_vec_t TRAP_FLUSH_FLUSH = 6'b001110;
  localparam ctl_vec_t TRAP_STALL_STALL = 6'b111111;
  localparam ctl_vec_t TRAP_STALL_FLUSH = 6'b000000;
  localparam ctl_vec_t JUMP_STALL       = 6'b000000;
  localparam ctl_vec_t JUMP_FLUSH       = 6'b000110;
  localparam ctl_vec_t MUL_DIV_STALL    = 6'b001111;
  localparam ctl_vec_t MUL_DIV_FLUSH    = 6'b010000;
  localparam ctl_vec_t LOAD_USE_STALL   = 6'b000111;
  localparam ctl_vec_t LOAD_USE_FLUSH   = 6'b001000;
  localparam ctl_vec_t COMPRESS_STALL   = 6'b000011;
  localparam ctl_vec_t COMPRESS_FLUSH   = 6'b000100;
  localparam ctl_vec_t RESET_STALL      = 6'b000000;
  localparam ctl_vec_t RESET_FLUSH      = 6'b011111;

endpackage

// ==== source/pipe_ctrl_if.sv ====
`include "cpu_pipe_settings.svh"

interface pipe_ctrl_if;

  // resolved control vectors, bit 0 = pc
  logic [`CPU_PIPE_STAGES-1:0] stall;
  logic [`CPU_PIPE_STAGES-1:0] flush;

  // load in id/ex feeds the instruction in if/id
  logic load_use_valid;

  // id/ex holds a valid mul/div op
  logic ex_muldiv;

  // mul/div unit still busy, keep id/ex
  logic mul_div_valid;

  // priority resolver
  modport ctrl (
    output stall,
    output flush,
    input  load_use_valid,
    input  mul_div_valid
  );

  // stage registers and pc
  modport chain (
    input  stall,
    input  flush,
    output load_use_valid,
    output ex_muldiv
  );

  // occupancy counter
  modport muldiv (
    input  ex_muldiv,
    output mul_div_valid
  );

endinterface

// ==== source/pipeline_control.sv ====
`include "cpu_pipe_settings.svh"

module pipeline_control (
  input  logic rst_i,
  input  logic ram_stall_if_i,
  input  logic ram_stall_mem_i,
  input  logic next_stall_preif_i,
  input  logic trap_stall_i,
  input  logic trap_flush_i,
  input  logic jump_valid_i,
  input  logic compress_stall_i,
  pipe_ctrl_if.ctrl ctl
);

  cpu_pipe_pkg::ctl_vec_t stall_d;
  cpu_pipe_pkg::ctl_vec_t flush_d;

  // anything that outranks trap_stall in the list below
  logic above_trap_stall;

  // later pipeline events win, reset wins over everything
  always_comb begin
    if (rst_i) begin
      // hold nothing, empty every stage register behind mem/wb
      stall_d = cpu_pipe_pkg::RESET_STALL;
      flush_d = cpu_pipe_pkg::RESET_FLUSH;
    end else if (ram_stall_mem_i) begin
      // data memory busy, freeze everything ahead of mem/wb
      stall_d = cpu_pipe_pkg::RAM_MEM_STALL;
      flush_d = cpu_pipe_pkg::RAM_MEM_FLUSH;
    end else if (ram_stall_if_i) begin
      // fetch not ready, bubble into if/id
      stall_d = cpu_pipe_pkg::RAM_IF_STALL;
      flush_d = cpu_pipe_pkg::RAM_IF_FLUSH;
    end else if (next_stall_preif_i) begin
      // pre-if holds, pc keeps running ahead
      stall_d = cpu_pipe_pkg::NEXT_PREIF_STALL;
      flush_d = cpu_pipe_pkg::NEXT_PREIF_FLUSH;
    end else if (trap_flush_i) begin
      // drop the three younger slots, pc goes to the trap vector
      stall_d = cpu_pipe_pkg::TRAP_FLUSH_STALL;
      flush_d = cpu_pipe_pkg::TRAP_FLUSH_FLUSH;
    end else if (trap_stall_i) begin
      // freeze the whole pipe
      stall_d = cpu_pipe_pkg::TRAP_STALL_STALL;
      flush_d = cpu_pipe_pkg::TRAP_STALL_FLUSH;
    end else if (jump_valid_i) begin
      // two wrong-path slots behind the redirect
      stall_d = cpu_pipe_pkg::JUMP_STALL;
      flush_d = cpu_pipe_pkg::JUMP_FLUSH;
    end else if (ctl.mul_div_valid) begin
      // op sits in id/ex, bubble goes to ex/mem
      stall_d = cpu_pipe_pkg::MUL_DIV_STALL;
      flush_d = cpu_pipe_pkg::MUL_DIV_FLUSH;
    end else if (ctl.load_use_valid) begin
      // consumer waits in if/id for one cycle
      stall_d = cpu_pipe_pkg::LOAD_USE_STALL;
      flush_d = cpu_pipe_pkg::LOAD_USE_FLUSH;
    end else if (compress_stall_i) begin
      // second half of a compressed pair, bubble into if/id
      stall_d = cpu_pipe_pkg::COMPRESS_STALL;
      flush_d = cpu_pipe_pkg::COMPRESS_FLUSH;
    end else begin
      stall_d = '0;
      flush_d = '0;
    end
  end

  assign ctl.stall = stall_d;
  assign ctl.flush = flush_d;

  assign above_trap_stall = rst_i | ram_stall_mem_i | ram_stall_if_i |
                            next_stall_preif_i | trap_flush_i;

  // checks on the resolved pair
  always_comb begin
    // full freeze only comes from a winning trap_stall
    if (&stall_d) begin
      assert (trap_stall_i && !above_trap_stall)
        else $error("full stall without a winning trap_stall");
    end
    // a stage is either held or emptied, never both
    if (!rst_i) begin
      assert ((stall_d & flush_d) == '0)
        else $error("stall and flush overlap: %b %b", stall_d, flush_d);
    end
  end

endmodule

// ==== source/mul_div_busy.sv ====
`include "cpu_pipe_settings.svh"

module mul_div_busy (
  input  logic clk,
  input  logic rst,
  pipe_ctrl_if.muldiv ctl
);

  localparam int CYC = `CPU_PIPE_MULDIV_CYCLES;
  localparam int CW  = $clog2(CYC + 1);

  // cycles the op in id/ex has been held so far
  logic [CW-1:0] cnt_q;

  // op present and still short of its latency
  logic counting;

  assign counting = ctl.ex_muldiv && (cnt_q < CW'(CYC));

  // stall request follows the counter directly
  assign ctl.mul_div_valid = counting;

  // at CYC the request drops for one cycle so the op can leave,
  // then the counter is back at zero for the next op
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (counting) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      cnt_q <= '0;
    end
  end

  // counter stays inside its range
  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    cnt_q <= CW'(CYC)
  ) else $error("mul/div counter out of range: %0d", cnt_q);

endmodule

// ==== source/pipe_stage_chain.sv ====
`include "cpu_pipe_settings.svh"

module pipe_stage_chain (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`CPU_PIPE_XLEN-1:0] fetch_instr_i,
  input  logic [`CPU_PIPE_XLEN-1:0] jump_target_i,
  input  logic                      trap_flush_i,
  input  logic                      jump_valid_i,
  pipe_ctrl_if.chain                ctl,
  output logic [`CPU_PIPE_XLEN-1:0] fetch_pc_o,
  output logic                      retire_valid_o,
  output logic [`CPU_PIPE_XLEN-1:0] retire_pc_o,
  output logic [`CPU_PIPE_XLEN-1:0] retire_instr_o
);

  localparam int LAST = `CPU_PIPE_STAGES - 1;

  logic [`CPU_PIPE_XLEN-1:0] pc_q;

  // stage registers 1..5, pre-if up to mem/wb
  cpu_pipe_pkg::stage_rec_t stage_q [1:LAST];

  // what each stage would take when it advances
  cpu_pipe_pkg::stage_rec_t up_d [1:LAST];

  // pc redirect wins when pre-if is emptied without being held
  logic redirect;

  // instruction views used by the hazard checks
  cpu_pipe_pkg::rv_instr_u ex_instr;
  cpu_pipe_pkg::rv_instr_u id_instr;
  logic                    ex_is_load;
  logic                    id_is_op;
  logic                    rs1_hit;
  logic                    rs2_hit;

  // only trap_flush and jump set flush bit 1 while bit 1 is not held
  assign redirect = ctl.flush[cpu_pipe_pkg::PRE_IF] & ~ctl.stall[cpu_pipe_pkg::PRE_IF];

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `CPU_PIPE_RESET_PC;
    end else if (!ctl.stall[cpu_pipe_pkg::PC]) begin
      if (redirect) begin
        // trap outranks jump, so trap_flush_i only picks the target
        pc_q <= trap_flush_i ? `CPU_PIPE_TRAP_VECTOR : jump_target_i;
      end else begin
        pc_q <= pc_q + `CPU_PIPE_XLEN'(4);
      end
    end
  end

  // upstream sources
  always_comb begin
    // pre-if samples the pc, always a real fetch slot
    up_d[cpu_pipe_pkg::PRE_IF].valid = 1'b1;
    up_d[cpu_pipe_pkg::PRE_IF].pc    = pc_q;
    up_d[cpu_pipe_pkg::PRE_IF].instr = '0;
    // if/id joins the pre-if pc with the fetched word
    up_d[cpu_pipe_pkg::IF_ID].valid = stage_q[cpu_pipe_pkg::PRE_IF].valid;
    up_d[cpu_pipe_pkg::IF_ID].pc    = stage_q[cpu_pipe_pkg::PRE_IF].pc;
    up_d[cpu_pipe_pkg::IF_ID].instr = fetch_instr_i;
    // the rest simply shift
    for (int k = cpu_pipe_pkg::ID_EX; k <= LAST; k++) begin
      up_d[k] = stage_q[k - 1];
    end
  end

  // stall holds, else flush leaves a bubble, else advance
  // payload follows even into a bubble, only valid matters there
  always_ff @(posedge clk) begin
    for (int k = 1; k <= LAST; k++) begin
      if (rst) begin
        stage_q[k].valid <= 1'b0;
      end else if (!ctl.stall[k]) begin
        stage_q[k].valid <= up_d[k].valid & ~ctl.flush[k];
        stage_q[k].pc    <= up_d[k].pc;
        stage_q[k].instr <= up_d[k].instr;
      end
    end
  end

  assign ex_instr = stage_q[cpu_pipe_pkg::ID_EX].instr;
  assign id_instr = stage_q[cpu_pipe_pkg::IF_ID].instr;

  // load check reads the I layout
  assign ex_is_load = stage_q[cpu_pipe_pkg::ID_EX].valid &&
                      (ex_instr.i.opcode == cpu_pipe_pkg::OPC_LOAD) &&
                      (ex_instr.i.rd != 5'd0);

  // rs2 is a real source only for register-register ops
  assign id_is_op = id_instr.r.opcode == cpu_pipe_pkg::OPC_OP;
  assign rs1_hit  = ex_instr.i.rd == id_instr.i.rs1;
  assign rs2_hit  = id_is_op && (ex_instr.i.rd == id_instr.r.rs2);

  assign ctl.load_use_valid = ex_is_load && stage_q[cpu_pipe_pkg::IF_ID].valid &&
                              (rs1_hit || rs2_hit);

  // M extension ops carry funct7 = 1
  assign ctl.ex_muldiv = stage_q[cpu_pipe_pkg::ID_EX].valid &&
                         (ex_instr.r.opcode == cpu_pipe_pkg::OPC_OP) &&
                         (ex_instr.r.funct7 == 7'd1);

  // pre-if pc is what the fetch word must belong to
  assign fetch_pc_o     = stage_q[cpu_pipe_pkg::PRE_IF].pc;
  assign retire_valid_o = stage_q[cpu_pipe_pkg::MEM_WB].valid;
  assign retire_pc_o    = stage_q[cpu_pipe_pkg::MEM_WB].pc;
  assign retire_instr_o = stage_q[cpu_pipe_pkg::MEM_WB].instr;

  // a flushed stage that was not held is a bubble one cycle later
  for (genvar g = 1; g <= LAST; g++) begin : g_flush_chk
    a_bubble: assert property (
      @(posedge clk) disable iff (rst)
      (ctl.flush[g] && !ctl.stall[g]) |=> !stage_q[g].valid
    ) else $error("stage %0d still valid after flush", g);
  end

  // jump_valid_i only matters through the resolved vectors
  a_jump_redirect: assert property (
    @(posedge clk) disable iff (rst)
    (redirect && !trap_flush_i) |-> jump_valid_i
  ) else $error("redirect without a jump or trap request");

endmodule

// ==== source/cpu_pipe_top.sv ====
`include "cpu_pipe_settings.svh"

module cpu_pipe_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`CPU_PIPE_XLEN-1:0]   fetch_instr_i,
  input  logic [`CPU_PIPE_XLEN-1:0]   jump_target_i,
  input  logic                        ram_stall_if_i,
  input  logic                        ram_stall_mem_i,
  input  logic                        next_stall_preif_i,
  input  logic                        trap_stall_i,
  input  logic                        trap_flush_i,
  input  logic                        jump_valid_i,
  input  logic                        compress_stall_i,
  output logic [`CPU_PIPE_STAGES-1:0] stall_o,
  output logic [`CPU_PIPE_STAGES-1:0] flush_o,
  output logic [`CPU_PIPE_XLEN-1:0]   fetch_pc_o,
  output logic                        retire_valid_o,
  output logic [`CPU_PIPE_XLEN-1:0]   retire_pc_o,
  output logic [`CPU_PIPE_XLEN-1:0]   retire_instr_o
);

  // internal hazard bus between resolver, counter and stages
  pipe_ctrl_if ctl_if ();

  pipeline_control pipeline_control_i (
    .rst_i              (rst),
    .ram_stall_if_i     (ram_stall_if_i),
    .ram_stall_mem_i    (ram_stall_mem_i),
    .next_stall_preif_i (next_stall_preif_i),
    .trap_stall_i       (trap_stall_i),
    .trap_flush_i       (trap_flush_i),
    .jump_valid_i       (jump_valid_i),
    .compress_stall_i   (compress_stall_i),
    .ctl                (ctl_if.ctrl)
  );

  mul_div_busy mul_div_busy_i (
    .clk (clk),
    .rst (rst),
    .ctl (ctl_if.muldiv)
  );

  pipe_stage_chain pipe_stage_chain_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_instr_i  (fetch_instr_i),
    .jump_target_i  (jump_target_i),
    .trap_flush_i   (trap_flush_i),
    .jump_valid_i   (jump_valid_i),
    .ctl            (ctl_if.chain),
    .fetch_pc_o     (fetch_pc_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o)
  );

  // resolved vectors visible outside for debug and checking
  assign stall_o = ctl_if.stall;
  assign flush_o = ctl_if.flush;

endmodule

// ==== tests/cpu_pipe_tb.sv ====
`include "cpu_pipe_settings.svh"

module cpu_pipe_tb;

  localparam int NUM_CYCLES  = 3000;
  localparam int DRAIN_LIMIT = 64;
  localparam int RST_CYCLES  = 3;
  localparam int LAST        = `CPU_PIPE_STAGES - 1;
  localparam int MULDIV      = `CPU_PIPE_MULDIV_CYCLES;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // winning request, highest priority first
  localparam int W_RST        = 1;
  localparam int W_RAM_MEM    = 2;
  localparam int W_RAM_IF     = 3;
  localparam int W_NEXT_PREIF = 4;
  localparam int W_TRAP_FLUSH = 5;
  localparam int W_TRAP_STALL = 6;
  localparam int W_JUMP       = 7;
  localparam int W_MUL_DIV    = 8;
  localparam int W_LOAD_USE   = 9;
  localparam int W_COMPRESS   = 10;
  localparam int W_NONE       = 11;

  logic                        clk;
  logic                        rst;
  logic [`CPU_PIPE_XLEN-1:0]   fetch_instr;
  logic [`CPU_PIPE_XLEN-1:0]   jump_target;
  logic                        ram_stall_if;
  logic                        ram_stall_mem;
  logic                        next_stall_preif;
  logic                        trap_stall;
  logic                        trap_flush;
  logic                        jump_valid;
  logic                        compress_stall;
  logic [`CPU_PIPE_STAGES-1:0] stall_o;
  logic [`CPU_PIPE_STAGES-1:0] flush_o;
  logic [`CPU_PIPE_XLEN-1:0]   fetch_pc_o;
  logic                        retire_valid_o;
  logic [`CPU_PIPE_XLEN-1:0]   retire_pc_o;
  logic [`CPU_PIPE_XLEN-1:0]   retire_instr_o;

  // reference pipeline, stage 1 is pre-if, stage 5 is mem/wb
  logic                        m_valid [1:LAST];
  logic [`CPU_PIPE_XLEN-1:0]   m_pc    [1:LAST];
  logic [`CPU_PIPE_XLEN-1:0]   m_instr [1:LAST];
  logic [`CPU_PIPE_XLEN-1:0]   m_pc_reg;
  int                          m_cnt;
  logic                        m_busy;
  int                          winner;
  logic [`CPU_PIPE_STAGES-1:0] exp_stall;
  logic [`CPU_PIPE_STAGES-1:0] exp_flush;

  // pending redirect: survivors drain first, then the target must retire
  logic                        pend;
  logic                        pend_captured;
  logic                        pend_bound_valid;
  logic [`CPU_PIPE_XLEN-1:0]   pend_bound;
  logic [`CPU_PIPE_XLEN-1:0]   pend_target;

  logic [31:0]                 seed = 32'd80;
  logic [`CPU_PIPE_XLEN-1:0]   drain_pc;
  logic                        drained;
  int                          waited;
  int                          n_load_use;
  int                          n_muldiv;
  int                          n_redirect;

  cpu_pipe_top cpu_pipe_top_i (
    .clk                (clk),
    .rst                (rst),
    .fetch_instr_i      (fetch_instr),
    .jump_target_i      (jump_target),
    .ram_stall_if_i     (ram_stall_if),
    .ram_stall_mem_i    (ram_stall_mem),
    .next_stall_preif_i (next_stall_preif),
    .trap_stall_i       (trap_stall),
    .trap_flush_i       (trap_flush),
    .jump_valid_i       (jump_valid),
    .compress_stall_i   (compress_stall),
    .stall_o            (stall_o),
    .flush_o            (flush_o),
    .fetch_pc_o         (fetch_pc_o),
    .retire_valid_o     (retire_valid_o),
    .retire_pc_o        (retire_pc_o),
    .retire_instr_o     (retire_instr_o)
  );

  // starts high so the first event is a falling edge
  initial begin
    clk = 1'b1;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rand_next();
    seed = lcg_step(seed);
    return seed;
  endfunction

  // true with probability thr/256
  function automatic logic chance(input logic [7:0] thr);
    logic [31:0] r;
    r = rand_next();
    return r[23:16] < thr;
  endfunction

  // fixed word per pc, mostly loads, ops and muls on x0..x3
  function automatic logic [31:0] instr_hash(input logic [31:0] pc);
    logic [31:0] h;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    h   = lcg_step(lcg_step(pc ^ 32'h2545_f491));
    rd  = {3'b000, h[17:16]};
    rs1 = {3'b000, h[19:18]};
    rs2 = {3'b000, h[21:20]};
    case (h[26:24])
      3'd0, 3'd1, 3'd2: return {h[11:0], rs1, 3'b010, rd, OPC_LOAD};
      3'd3, 3'd4:       return {7'd0, rs2, rs1, 3'b000, rd, OPC_OP};
      3'd5:             return {7'd1, rs2, rs1, h[30:28], rd, OPC_OP};
      default:          return {h[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
    endcase
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped at time %0t", $time);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic drive_inputs(input logic quiet, input int cyc);
    logic [31:0] r;
    rst              = cyc < RST_CYCLES;
    ram_stall_mem    = !quiet && chance(8'd6);
    ram_stall_if     = !quiet && chance(8'd8);
    next_stall_preif = !quiet && chance(8'd6);
    trap_flush       = !quiet && chance(8'd3);
    trap_stall       = !quiet && chance(8'd5);
    jump_valid       = !quiet && chance(8'd10);
    compress_stall   = !quiet && chance(8'd8);
    r = rand_next();
    jump_target = {16'h8000, r[31:18], 2'b00};
    // fetch memory answers for the pc in pre-if
    fetch_instr = instr_hash(m_valid[1] ? m_pc[1] : 32'd0);
  endtask

  // internal hazards from the model records, then the priority list
  task automatic resolve_model();
    logic [31:0] ex;
    logic [31:0] id;
    logic        ld_hit;
    ex = m_instr[3];
    id = m_instr[2];
    ld_hit = m_valid[3] && ex[6:0] == OPC_LOAD && ex[11:7] != 5'd0 && m_valid[2] &&
             (ex[11:7] == id[19:15] || (id[6:0] == OPC_OP && ex[11:7] == id[24:20]));
    m_busy = m_valid[3] && ex[6:0] == OPC_OP && ex[31:25] == 7'd1 && m_cnt < MULDIV;
    if (rst) winner = W_RST;
    else if (ram_stall_mem) winner = W_RAM_MEM;
    else if (ram_stall_if) winner = W_RAM_IF;
    else if (next_stall_preif) winner = W_NEXT_PREIF;
    else if (trap_flush) winner = W_TRAP_FLUSH;
    else if (trap_stall) winner = W_TRAP_STALL;
    else if (jump_valid) winner = W_JUMP;
    else if (m_busy) winner = W_MUL_DIV;
    else if (ld_hit) winner = W_LOAD_USE;
    else if (compress_stall) winner = W_COMPRESS;
    else winner = W_NONE;
    case (winner)
      W_RST:        {exp_stall, exp_flush} = {6'b000000, 6'b011111};
      W_RAM_MEM:    {exp_stall, exp_flush} = {6'b011111, 6'b100000};
      W_RAM_IF:     {exp_stall, exp_flush} = {6'b000011, 6'b000100};
      W_NEXT_PREIF: {exp_stall, exp_flush} = {6'b000010, 6'b000100};
      W_TRAP_FLUSH: {exp_stall, exp_flush} = {6'b000000, 6'b001110};
      W_TRAP_STALL: {exp_stall, exp_flush} = {6'b111111, 6'b000000};
      W_JUMP:       {exp_stall, exp_flush} = {6'b000000, 6'b000110};
      W_MUL_DIV:    {exp_stall, exp_flush} = {6'b001111, 6'b010000};
      W_LOAD_USE:   {exp_stall, exp_flush} = {6'b000111, 6'b001000};
      W_COMPRESS:   {exp_stall, exp_flush} = {6'b000011, 6'b000100};
      default:      {exp_stall, exp_flush} = {6'b000000, 6'b000000};
    endcase
  endtask

  task automatic track_redirect();
    logic retired;
    retired = !rst && retire_valid_o && !exp_stall[5];
    if (pend && retired) begin
      if (pend_bound_valid) begin
        // older survivor leaving, target comes after the youngest one
        if (retire_pc_o == pend_bound) pend_bound_valid = 1'b0;
      end else begin
        compare_value("redirect target", pend_target, retire_pc_o);
        pend = 1'b0;
        n_redirect++;
      end
    end
    if (rst) begin
      pend = 1'b0;
    end else if (pend && !pend_captured) begin
      if (!exp_stall[1] && !exp_flush[1]) pend_captured = 1'b1;
      // pc moved past the target before pre-if took it
      else if (!exp_stall[0] && winner != W_JUMP && winner != W_TRAP_FLUSH) pend = 1'b0;
    end
    if (winner == W_JUMP || winner == W_TRAP_FLUSH) begin
      pend             = 1'b1;
      pend_captured    = 1'b0;
      pend_target      = (winner == W_TRAP_FLUSH) ? `CPU_PIPE_TRAP_VECTOR : jump_target;
      pend_bound_valid = 1'b0;
      // mem/wb retires this cycle, so only stages 1..4 can be survivors
      for (int k = 4; k >= 1; k--) begin
        if (m_valid[k] && !exp_flush[k+1]) begin
          pend_bound_valid = 1'b1;
          pend_bound       = m_pc[k];
        end
      end
    end
  endtask

  // stage rule, pc rule and mul/div counter, oldest stage first
  task automatic advance_model();
    for (int k = LAST; k >= 1; k--) begin
      if (rst) begin
        m_valid[k] = 1'b0;
      end else if (!exp_stall[k]) begin
        if (k == 1) begin
          m_valid[1] = !exp_flush[1];
          m_pc[1]    = m_pc_reg;
          m_instr[1] = '0;
        end else if (k == 2) begin
          m_valid[2] = m_valid[1] && !exp_flush[2];
          m_pc[2]    = m_pc[1];
          m_instr[2] = fetch_instr;
        end else begin
          m_valid[k] = m_valid[k-1] && !exp_flush[k];
          m_pc[k]    = m_pc[k-1];
          m_instr[k] = m_instr[k-1];
        end
      end
    end
    if (rst) m_pc_reg = `CPU_PIPE_RESET_PC;
    else if (!exp_stall[0]) begin
      if (winner == W_TRAP_FLUSH) m_pc_reg = `CPU_PIPE_TRAP_VECTOR;
      else if (winner == W_JUMP) m_pc_reg = jump_target;
      else m_pc_reg = m_pc_reg + 32'd4;
    end
    m_cnt = (rst || !m_busy) ? 0 : m_cnt + 1;
  endtask

  task automatic run_cycle(input logic quiet, input int cyc);
    @(negedge clk);
    if (m_valid[1]) compare_value("fetch pc", m_pc[1], fetch_pc_o);
    drive_inputs(quiet, cyc);
    #1;
    resolve_model();
    compare_value("stall vector", 32'(exp_stall), 32'(stall_o));
    compare_value("flush vector", 32'(exp_flush), 32'(flush_o));
    // mem/wb is unknown before the first reset edge
    if (cyc > 0) compare_value("retire valid", 32'(m_valid[5]), 32'(retire_valid_o));
    if (cyc > 0 && m_valid[5]) begin
      compare_value("retire pc", m_pc[5], retire_pc_o);
      compare_value("retire instr", m_instr[5], retire_instr_o);
    end
    track_redirect();
    if (winner == W_LOAD_USE) n_load_use++;
    if (winner == W_MUL_DIV) n_muldiv++;
    advance_model();
  endtask

  initial begin
    rst              = 1'b1;
    fetch_instr      = '0;
    jump_target      = '0;
    ram_stall_if     = 1'b0;
    ram_stall_mem    = 1'b0;
    next_stall_preif = 1'b0;
    trap_stall       = 1'b0;
    trap_flush       = 1'b0;
    jump_valid       = 1'b0;
    compress_stall   = 1'b0;
    for (int k = 1; k <= LAST; k++) begin
      m_valid[k] = 1'b0;
      m_pc[k]    = '0;
      m_instr[k] = '0;
    end
    m_pc_reg   = `CPU_PIPE_RESET_PC;
    m_cnt      = 0;
    pend       = 1'b0;
    n_load_use = 0;
    n_muldiv   = 0;
    n_redirect = 0;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      run_cycle(1'b0, cyc);
    end
    // strobes quiet, wait for the next pc to come out of mem/wb
    drain_pc = m_pc_reg;
    drained  = 1'b0;
    waited   = 0;
    while (!drained && waited < DRAIN_LIMIT) begin
      run_cycle(1'b1, NUM_CYCLES + waited);
      if (retire_valid_o && retire_pc_o == drain_pc) drained = 1'b1;
      waited++;
    end
    if (!drained) begin
      stop_on_error("pipeline did not drain within the drain limit");
    end else if (n_load_use == 0 || n_muldiv == 0 || n_redirect == 0) begin
      stop_on_error("stimulus never produced a load-use, mul/div or redirect case");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== cpu_pipe.f ====
+incdir+source
source/cpu_pipe_pkg.sv
source/pipe_ctrl_if.sv
source/pipeline_control.sv
source/mul_div_busy.sv
source/pipe_stage_chain.sv
source/cpu_pipe_top.sv
tests/cpu_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cpu_pipe testbench with Verilator, run it and judge the result
# from the simulation output.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module cpu_pipe_tb -f cpu_pipe.f -o cpu_pipe_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/cpu_pipe_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF '>>> PASS'; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
